// ==== flist.f ====
+incdir+testbench
verilog/mipsDecodePkg.sv
verilog/decodeIf.sv
verilog/wbDecodeSlave.sv
verilog/controlUnit.sv
verilog/immediateUnit.sv
verilog/decodeMerge.sv
verilog/mipsDecodeTop.sv
testbench/tbMipsDecode.sv

// ==== Bender.yml ====
package:
  name: mipsDecode

sources:
  - verilog/mipsDecodePkg.sv
  - verilog/decodeIf.sv
  - verilog/wbDecodeSlave.sv
  - verilog/controlUnit.sv
  - verilog/immediateUnit.sv
  - verilog/decodeMerge.sv
  - verilog/mipsDecodeTop.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tbMipsDecode.sv

// ==== testbench/decodeModel.svh ====
`ifndef decodeModelSvh
`define decodeModelSvh

// Control word from the decode rules, packed in register layout order
function automatic logic [31:0] controlModel(input logic [31:0] ins, input logic hold);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic        isLoad;
    logic        isJumpReg;
    logic [1:0]  regWrite;
    logic [1:0]  regDst;
    logic [2:0]  memToReg;
    logic [1:0]  hiWrite;
    logic [1:0]  loWrite;
    logic [1:0]  storeType;
    logic        jr;
    logic        jump;
    logic        memRead;
    logic        memWrite;
    logic        delayEarly;
    op         = ins[31:26];
    fn         = ins[5:0];
    regWrite   = 2'd0;
    regDst     = 2'd0;
    memToReg   = 3'd0;
    hiWrite    = 2'd0;
    loWrite    = 2'd0;
    storeType  = 2'd0;
    jr         = 1'b0;
    jump       = 1'b0;
    memRead    = 1'b0;
    memWrite   = 1'b0;
    delayEarly = 1'b0;
    case (op)
        mipsDecodePkg::opLb, mipsDecodePkg::opLh, mipsDecodePkg::opLwl, mipsDecodePkg::opLw,
        mipsDecodePkg::opLbu, mipsDecodePkg::opLhu, mipsDecodePkg::opLwr: isLoad = 1'b1;
        default: isLoad = 1'b0;
    endcase
    isJumpReg = (op == mipsDecodePkg::opSpecial) &&
                (fn == mipsDecodePkg::fnJr || fn == mipsDecodePkg::fnJalr);
    if (hold && isLoad)
    begin
        memWrite = 1'b1;
        memToReg = 3'd1;
    end
    else if (!hold || isJumpReg)
    begin
        case (op)
            mipsDecodePkg::opSpecial:
            begin
                regDst = 2'd1;
                case (fn)
                    mipsDecodePkg::fnJr:
                    begin
                        jr         = 1'b1;
                        delayEarly = 1'b1;
                    end
                    mipsDecodePkg::fnJalr:
                    begin
                        jr         = 1'b1;
                        delayEarly = 1'b1;
                        regWrite   = 2'd3;
                        memToReg   = 3'd5;
                    end
                    mipsDecodePkg::fnMthi: hiWrite = 2'd3;
                    mipsDecodePkg::fnMtlo: loWrite = 2'd3;
                    mipsDecodePkg::fnMult, mipsDecodePkg::fnMultu,
                    mipsDecodePkg::fnDiv, mipsDecodePkg::fnDivu:
                    begin
                        hiWrite = 2'd3;
                        loWrite = 2'd3;
                    end
                    default:
                    begin
                        regWrite = 2'd3;
                        if (fn == mipsDecodePkg::fnMfhi)
                            memToReg = 3'd3;
                        if (fn == mipsDecodePkg::fnMflo)
                            memToReg = 3'd4;
                    end
                endcase
            end
            mipsDecodePkg::opSb, mipsDecodePkg::opSh, mipsDecodePkg::opSw:
            begin
                memWrite = 1'b1;
                if (op == mipsDecodePkg::opSh)
                    storeType = 2'd1;
                if (op == mipsDecodePkg::opSb)
                    storeType = 2'd2;
            end
            mipsDecodePkg::opJ, mipsDecodePkg::opJal:
            begin
                jump       = 1'b1;
                delayEarly = 1'b1;
                if (op == mipsDecodePkg::opJal)
                begin
                    regWrite = 2'd3;
                    regDst   = 2'd2;
                    memToReg = 3'd5;
                end
            end
            mipsDecodePkg::opBeq, mipsDecodePkg::opBne, mipsDecodePkg::opBlez,
            mipsDecodePkg::opBgtz, mipsDecodePkg::opRegimm:
            begin
                delayEarly = 1'b1;
                // BLTZAL and BGEZAL link to r31
                if (op == mipsDecodePkg::opRegimm && (ins[20:16] == 5'h10 || ins[20:16] == 5'h11))
                begin
                    regWrite = 2'd3;
                    regDst   = 2'd2;
                    memToReg = 3'd5;
                end
            end
            default:
            begin
                regWrite = 2'd3;
                if (isLoad)
                begin
                    memRead  = 1'b1;
                    memToReg = 3'd1;
                end
                if (op == mipsDecodePkg::opLwl)
                    regWrite = 2'd1;
                if (op == mipsDecodePkg::opLwr)
                    regWrite = 2'd2;
            end
        endcase
    end
    return {14'd0, storeType, delayEarly, loWrite, hiWrite, memToReg, regDst,
            memWrite, memRead, regWrite, jump, jr};
endfunction

function automatic logic [31:0] extendImmediate(input logic [31:0] ins);
    case (ins[31:26])
        mipsDecodePkg::opAndi, mipsDecodePkg::opOri, mipsDecodePkg::opXori:
            return {16'd0, ins[15:0]};
        mipsDecodePkg::opLui: return {ins[15:0], 16'd0};
        default: return {{16{ins[15]}}, ins[15:0]};
    endcase
endfunction

// Register indices, destination, shift amount and branch condition
function automatic logic [31:0] indexModel(input logic [31:0] ins, input logic hold);
    logic [31:0] ctrl;
    logic [4:0]  dest;
    logic [2:0]  cond;
    ctrl = controlModel(ins, hold);
    if (ctrl[3:2] == 2'd0)
        dest = 5'd0;
    else if (ctrl[7:6] == 2'd1)
        dest = ins[15:11];
    else if (ctrl[7:6] == 2'd2)
        dest = 5'd31;
    else
        dest = ins[20:16];
    case (ins[31:26])
        mipsDecodePkg::opBeq:    cond = 3'd1;
        mipsDecodePkg::opBne:    cond = 3'd2;
        mipsDecodePkg::opBlez:   cond = 3'd3;
        mipsDecodePkg::opBgtz:   cond = 3'd4;
        mipsDecodePkg::opRegimm: cond = 3'd5;
        default:                 cond = 3'd0;
    endcase
    return {9'd0, cond, ins[10:6], dest, ins[20:16], ins[25:21]};
endfunction

function automatic logic [31:0] expectedRead(input int adr, input logic [31:0] ins,
                                             input logic hold);
    case (adr)
        0: return ins;
        1: return {31'd0, hold};
        2: return controlModel(ins, hold);
        3: return extendImmediate(ins);
        4: return indexModel(ins, hold);
        default: return 32'd0;
    endcase
endfunction

`endif

// ==== testbench/tbMipsDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbMipsDecode;

    localparam int AddrWidth   = 3;
    localparam int NumPerGroup = 32;
    // Reset reads, six instruction groups of seven accesses, unmapped checks
    localparam int NumTrans    = 8 + 6 * NumPerGroup * 7 + 8;
    localparam int CycleLimit  = 20 * NumTrans;

    logic                 clk;
    logic                 rstN;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [AddrWidth-1:0] wbAdr;
    logic [31:0]          wbDatI;
    logic [31:0]          wbDatO;
    logic                 wbAck;

    integer      seed;
    int          valueErrors;
    int          protocolErrors;
    int          checks;
    int          cycles;
    int          i;
    int          k;
    logic [31:0] ins;
    logic [31:0] rd;
    logic [31:0] instrQ[$];

    logic [5:0] rtypeFuncts [0:9] = '{
        mipsDecodePkg::fnJr, mipsDecodePkg::fnJalr, mipsDecodePkg::fnMfhi,
        mipsDecodePkg::fnMthi, mipsDecodePkg::fnMflo, mipsDecodePkg::fnMtlo,
        mipsDecodePkg::fnMult, mipsDecodePkg::fnMultu, mipsDecodePkg::fnDiv,
        mipsDecodePkg::fnDivu};
    logic [5:0] memOps [0:13] = '{
        mipsDecodePkg::opLb, mipsDecodePkg::opLh, mipsDecodePkg::opLwl, mipsDecodePkg::opLw,
        mipsDecodePkg::opLbu, mipsDecodePkg::opLhu, mipsDecodePkg::opLwr, mipsDecodePkg::opSb,
        mipsDecodePkg::opSh, mipsDecodePkg::opSw, mipsDecodePkg::opAndi, mipsDecodePkg::opOri,
        mipsDecodePkg::opXori, mipsDecodePkg::opLui};
    logic [5:0] flowOps [0:6] = '{
        mipsDecodePkg::opJ, mipsDecodePkg::opJal, mipsDecodePkg::opBeq, mipsDecodePkg::opBne,
        mipsDecodePkg::opBlez, mipsDecodePkg::opBgtz, mipsDecodePkg::opRegimm};

    `include "decodeModel.svh"

    mipsDecodeTop #(
        .WbAddrWidth (AddrWidth)
    ) dut0 (
        .clk    (clk),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatI (wbDatI),
        .wbDatO (wbDatO),
        .wbAck  (wbAck)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles < CycleLimit)
        begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("Run stopped by timeout after %0d cycles", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            valueErrors++;
            $display("** Error %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic busAccess(input logic we, input logic [AddrWidth-1:0] adr,
                             input logic [31:0] data, output logic [31:0] rdata);
        int   waitCycles;
        logic gotAck;
        wbCyc      = 1'b1;
        wbStb      = 1'b1;
        wbWe       = we;
        wbAdr      = adr;
        wbDatI     = data;
        waitCycles = 0;
        gotAck     = 1'b0;
        rdata      = 32'd0;
        while (!gotAck && waitCycles < 8)
        begin
            @(posedge clk);
            #2;
            waitCycles++;
            gotAck = wbAck;
        end
        if (!gotAck)
        begin
            protocolErrors++;
            $display("No ack from the DUT within 8 cycles, address %0d", adr);
        end
        else
        begin
            rdata = wbDatO;
            // Strobe still high for one cycle after ack
            @(posedge clk);
            #2;
            if (wbAck !== 1'b0)
            begin
                protocolErrors++;
                $display("DUT gave more than one ack for an access to address %0d", adr);
            end
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic writeReg(input int adr, input logic [31:0] data);
        logic [31:0] ignored;
        busAccess(1'b1, adr[AddrWidth-1:0], data, ignored);
    endtask

    task automatic readReg(input int adr, output logic [31:0] data);
        busAccess(1'b0, adr[AddrWidth-1:0], 32'd0, data);
    endtask

    // Loads the instruction and hold flag, then reads back all mapped words
    task automatic runInstr(input string name, input logic [31:0] word, input logic hold);
        logic [31:0] holdData;
        logic [31:0] rdata;
        int          a;
        holdData    = $random(seed);
        holdData[0] = hold;
        writeReg(0, word);
        writeReg(1, holdData);
        for (a = 0; a < 5; a++)
        begin
            readReg(a, rdata);
            checkValue($sformatf("%s %08h addr %0d", name, word, a),
                       expectedRead(a, word, hold), rdata);
        end
    endtask

    // Kind 0 is R-type, 1 memory and immediate ALU, 2 jumps and branches
    function automatic logic [31:0] pickInstr(input int kind, input int n);
        logic [31:0] w;
        logic [1:0]  rtSel;
        int          size;
        int          sel;
        w     = $random(seed);
        rtSel = $random(seed);
        size  = (kind == 0) ? 12 : ((kind == 1) ? 14 : 7);
        // Every list entry once, then random picks
        sel   = (n < size) ? n : {$random(seed)} % size;
        case (kind)
            0:
            begin
                w[31:26] = 6'h00;
                if (sel < 10)
                    w[5:0] = rtypeFuncts[sel];
            end
            1: w[31:26] = memOps[sel];
            default:
            begin
                w[31:26] = flowOps[sel];
                if (flowOps[sel] == mipsDecodePkg::opRegimm)
                    w[20:16] = {rtSel[1], 3'b000, rtSel[0]};
            end
        endcase
        return w;
    endfunction

    initial
    begin
        rstN           = 1'b0;
        wbCyc          = 1'b0;
        wbStb          = 1'b0;
        wbWe           = 1'b0;
        wbAdr          = '0;
        wbDatI         = 32'd0;
        seed           = 32'ha984_e325;
        valueErrors    = 0;
        protocolErrors = 0;
        checks         = 0;
        repeat (10) @(posedge clk);
        #2;
        rstN = 1'b1;

        repeat (3)
        begin
            @(posedge clk);
            #2;
            checkValue("idle ack", 32'd0, {31'd0, wbAck});
        end
        // Decode of the cleared instruction register
        for (k = 0; k < 8; k++)
        begin
            readReg(k, rd);
            checkValue($sformatf("reset read addr %0d", k), expectedRead(k, 32'd0, 1'b0), rd);
        end

        for (i = 0; i < 3 * NumPerGroup; i++)
        begin
            ins = pickInstr(i / NumPerGroup, i % NumPerGroup);
            instrQ.push_back(ins);
            runInstr("decode", ins, 1'b0);
        end
        foreach (instrQ[j])
        begin
            runInstr("hold", instrQ[j], 1'b1);
        end

        for (k = 5; k < 8; k++)
        begin
            writeReg(k, $random(seed));
            readReg(k, rd);
            checkValue($sformatf("unmapped addr %0d", k), 32'd0, rd);
        end
        readReg(0, rd);
        checkValue("instr after unmapped writes", instrQ[$], rd);
        readReg(1, rd);
        checkValue("hold after unmapped writes", 32'd1, rd);

        $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                 checks, valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/mipsDecodeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsDecodeTop #(
    parameter int WbAddrWidth = 3
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   wbCyc,
    input  logic                   wbStb,
    input  logic                   wbWe,
    input  logic [WbAddrWidth-1:0] wbAdr,
    input  logic [31:0]            wbDatI,
    output logic [31:0]            wbDatO,
    output logic                   wbAck
);

    logic [31:0] ctrlWord;
    logic [31:0] immWord;
    logic [31:0] idxWord;

    decodeIf dec0 (
        .clk  (clk),
        .rstN (rstN)
    );

    wbDecodeSlave #(
        .WbAddrWidth (WbAddrWidth)
    ) slave0 (
        .clk      (clk),
        .rstN     (rstN),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatI   (wbDatI),
        .wbDatO   (wbDatO),
        .wbAck    (wbAck),
        .dec      (dec0.src),
        .ctrlWord (ctrlWord),
        .immWord  (immWord),
        .idxWord  (idxWord)
    );

    // Both decoders run in parallel on the stored instruction
    controlUnit ctrl0 (
        .dec (dec0.ctrl)
    );

    immediateUnit imm0 (
        .dec (dec0.opnd)
    );

    decodeMerge merge0 (
        .clk      (clk),
        .rstN     (rstN),
        .dec      (dec0.sink),
        .ctrlWord (ctrlWord),
        .immWord  (immWord),
        .idxWord  (idxWord)
    );

endmodule

`default_nettype wire

// ==== verilog/decodeMerge.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeMerge (
    input  logic        clk,
    input  logic        rstN,
    decodeIf.sink       dec,
    output logic [31:0] ctrlWord,
    output logic [31:0] immWord,
    output logic [31:0] idxWord
);

    logic [4:0]  destReg;
    logic [31:0] ctrlNext;
    logic [31:0] idxNext;

    // Destination is only meaningful when something is written
    always_comb
    begin
        if (dec.regWrite == 2'b00)
            destReg = 5'd0;
        else if (dec.regDst == mipsDecodePkg::selRd)
            destReg = dec.rdIdx;
        else if (dec.regDst == mipsDecodePkg::selRa)
            destReg = 5'd31;
        else
            destReg = dec.rtIdx;
    end

    always_comb
    begin
        ctrlNext = 32'd0;
        ctrlNext[mipsDecodePkg::CtrlJrPos]           = dec.jr;
        ctrlNext[mipsDecodePkg::CtrlJumpPos]         = dec.jump;
        ctrlNext[mipsDecodePkg::CtrlRegWriteLo +: 2] = dec.regWrite;
        ctrlNext[mipsDecodePkg::CtrlMemReadPos]      = dec.memRead;
        ctrlNext[mipsDecodePkg::CtrlMemWritePos]     = dec.memWrite;
        ctrlNext[mipsDecodePkg::CtrlRegDstLo +: 2]   = dec.regDst;
        ctrlNext[mipsDecodePkg::CtrlMemToRegLo +: 3] = dec.memToReg;
        ctrlNext[mipsDecodePkg::CtrlHiWriteLo +: 2]  = dec.hiWrite;
        ctrlNext[mipsDecodePkg::CtrlLoWriteLo +: 2]  = dec.loWrite;
        ctrlNext[mipsDecodePkg::CtrlDelayEarlyPos]   = dec.delayEarly;
        ctrlNext[mipsDecodePkg::CtrlStoreTypeLo +: 2] = dec.storeType;

        idxNext = 32'd0;
        idxNext[mipsDecodePkg::IdxRsLo +: 5]     = dec.rsIdx;
        idxNext[mipsDecodePkg::IdxRtLo +: 5]     = dec.rtIdx;
        idxNext[mipsDecodePkg::IdxDestLo +: 5]   = destReg;
        idxNext[mipsDecodePkg::IdxShamtLo +: 5]  = dec.shamt;
        idxNext[mipsDecodePkg::IdxBranchLo +: 3] = dec.branchCond;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            ctrlWord <= 32'd0;
            immWord  <= 32'd0;
            idxWord  <= 32'd0;
        end
        else
        begin
            ctrlWord <= ctrlNext;
            immWord  <= dec.immExt;
            idxWord  <= idxNext;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/immediateUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module immediateUnit (
    decodeIf.opnd dec
);

    mipsDecodePkg::opcodeE op;
    logic [15:0]           imm16;

    assign op    = mipsDecodePkg::opcodeE'(dec.instr[31:26]);
    assign imm16 = dec.instr[15:0];

    // Register fields of the R and I formats
    assign dec.rsIdx = dec.instr[25:21];
    assign dec.rtIdx = dec.instr[20:16];
    assign dec.rdIdx = dec.instr[15:11];
    assign dec.shamt = dec.instr[10:6];

    always_comb
    begin
        case (op)
            mipsDecodePkg::opBeq:    dec.branchCond = mipsDecodePkg::bcEq;
            mipsDecodePkg::opBne:    dec.branchCond = mipsDecodePkg::bcNe;
            mipsDecodePkg::opBlez:   dec.branchCond = mipsDecodePkg::bcLez;
            mipsDecodePkg::opBgtz:   dec.branchCond = mipsDecodePkg::bcGtz;
            // BLTZ, BGEZ and link forms are resolved later by rt
            mipsDecodePkg::opRegimm: dec.branchCond = mipsDecodePkg::bcRegimm;
            default:                 dec.branchCond = mipsDecodePkg::bcNone;
        endcase
    end

    always_comb
    begin
        case (op)
            mipsDecodePkg::opAndi,
            mipsDecodePkg::opOri,
            mipsDecodePkg::opXori:
            begin
                // Logical ops take an unsigned immediate
                dec.immExt = {16'd0, imm16};
            end
            mipsDecodePkg::opLui:
            begin
                dec.immExt = {imm16, 16'd0};
            end
            default:
            begin
                dec.immExt = {{16{imm16[15]}}, imm16};
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    decodeIf.ctrl dec
);

    mipsDecodePkg::opcodeE op;
    mipsDecodePkg::functE  fn;
    logic [4:0]            rt;
    logic                  isLoad;
    logic                  isStore;
    logic                  isBranch;
    logic                  isJumpReg;
    logic                  noWriteBack;

    assign op = mipsDecodePkg::opcodeE'(dec.instr[31:26]);
    assign fn = mipsDecodePkg::functE'(dec.instr[5:0]);
    assign rt = dec.instr[20:16];

    assign isLoad = op inside {mipsDecodePkg::opLb, mipsDecodePkg::opLh, mipsDecodePkg::opLwl,
                               mipsDecodePkg::opLw, mipsDecodePkg::opLbu, mipsDecodePkg::opLhu,
                               mipsDecodePkg::opLwr};
    assign isStore = op inside {mipsDecodePkg::opSb, mipsDecodePkg::opSh, mipsDecodePkg::opSw};
    assign isBranch = op inside {mipsDecodePkg::opBeq, mipsDecodePkg::opBne,
                                 mipsDecodePkg::opBlez, mipsDecodePkg::opBgtz,
                                 mipsDecodePkg::opRegimm};
    assign isJumpReg = (op == mipsDecodePkg::opSpecial) &&
                       (fn == mipsDecodePkg::fnJr || fn == mipsDecodePkg::fnJalr);

    // SPECIAL ops that leave the register file alone
    assign noWriteBack = fn inside {mipsDecodePkg::fnMthi, mipsDecodePkg::fnMtlo,
                                    mipsDecodePkg::fnMult, mipsDecodePkg::fnMultu,
                                    mipsDecodePkg::fnDiv, mipsDecodePkg::fnDivu,
                                    mipsDecodePkg::fnJr};

    always_comb
    begin
        dec.jr         = 1'b0;
        dec.jump       = 1'b0;
        dec.regWrite   = 2'b00;
        dec.memRead    = 1'b0;
        dec.memWrite   = 1'b0;
        dec.regDst     = mipsDecodePkg::selRt;
        dec.memToReg   = mipsDecodePkg::selAlu;
        dec.hiWrite    = 2'b00;
        dec.loWrite    = 2'b00;
        dec.delayEarly = 1'b0;
        dec.storeType  = mipsDecodePkg::stWord;

        if (dec.clkEn && isLoad)
        begin
            // Hold phase of a load
            dec.memWrite = 1'b1;
            dec.memToReg = mipsDecodePkg::selMem;
        end
        else if (!dec.clkEn || isJumpReg)
        begin
            if (op == mipsDecodePkg::opSpecial)
            begin
                dec.regDst = mipsDecodePkg::selRd;
                if (noWriteBack)
                begin
                    if (fn != mipsDecodePkg::fnMtlo && fn != mipsDecodePkg::fnJr)
                        dec.hiWrite = 2'b11;
                    if (fn != mipsDecodePkg::fnMthi && fn != mipsDecodePkg::fnJr)
                        dec.loWrite = 2'b11;
                    if (fn == mipsDecodePkg::fnJr)
                    begin
                        dec.jr         = 1'b1;
                        dec.delayEarly = 1'b1;
                    end
                end
                else
                begin
                    dec.regWrite = 2'b11;
                end
                if (fn == mipsDecodePkg::fnJalr)
                begin
                    dec.jr         = 1'b1;
                    dec.memToReg   = mipsDecodePkg::selLink;
                    dec.delayEarly = 1'b1;
                end
                else if (fn == mipsDecodePkg::fnMfhi)
                    dec.memToReg = mipsDecodePkg::selHi;
                else if (fn == mipsDecodePkg::fnMflo)
                    dec.memToReg = mipsDecodePkg::selLo;
            end

            // Everything else writes rt
            if (op != mipsDecodePkg::opSpecial && !isBranch && !isStore)
                dec.regWrite = 2'b11;
            // Partial word loads write only some lanes
            if (op == mipsDecodePkg::opLwl)
                dec.regWrite = 2'b01;
            if (op == mipsDecodePkg::opLwr)
                dec.regWrite = 2'b10;

            if (isStore)
            begin
                dec.memWrite = 1'b1;
                if (op == mipsDecodePkg::opSh)
                    dec.storeType = mipsDecodePkg::stHalf;
                else if (op == mipsDecodePkg::opSb)
                    dec.storeType = mipsDecodePkg::stByte;
            end
            if (isLoad)
            begin
                dec.memRead  = 1'b1;
                dec.memToReg = mipsDecodePkg::selMem;
            end

            if (op == mipsDecodePkg::opJ || op == mipsDecodePkg::opJal)
            begin
                dec.regWrite   = 2'b00;
                dec.jump       = 1'b1;
                dec.delayEarly = 1'b1;
            end
            // Link forms write the return address to r31
            if (op == mipsDecodePkg::opJal ||
                (op == mipsDecodePkg::opRegimm && (rt == 5'h10 || rt == 5'h11)))
            begin
                dec.regDst   = mipsDecodePkg::selRa;
                dec.memToReg = mipsDecodePkg::selLink;
                dec.regWrite = 2'b11;
            end
            if (isBranch)
                dec.delayEarly = 1'b1;
        end
    end

    noReadAndWrite: assert property (@(posedge dec.clk) disable iff (!dec.rstN)
        !(dec.memRead && dec.memWrite));

    noJrAndJump: assert property (@(posedge dec.clk) disable iff (!dec.rstN)
        !(dec.jr && dec.jump));

endmodule

`default_nettype wire

// ==== verilog/wbDecodeSlave.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbDecodeSlave #(
    parameter int WbAddrWidth = 3
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   wbCyc,
    input  logic                   wbStb,
    input  logic                   wbWe,
    input  logic [WbAddrWidth-1:0] wbAdr,
    input  logic [31:0]            wbDatI,
    output logic [31:0]            wbDatO,
    output logic                   wbAck,
    decodeIf.src                   dec,
    input  logic [31:0]            ctrlWord,
    input  logic [31:0]            immWord,
    input  logic [31:0]            idxWord
);

    mipsDecodePkg::wbStateE state;
    logic                   accept;
    logic [31:0]            instrReg;
    logic                   clkEnReg;
    logic [31:0]            rdData;

    // New access only from idle
    assign accept = (state == mipsDecodePkg::wbsIdle) && wbCyc && wbStb;

    assign dec.instr = instrReg;
    assign dec.clkEn = clkEnReg;

    always_comb
    begin
        case (wbAdr)
            WbAddrWidth'(mipsDecodePkg::AddrInstr): rdData = instrReg;
            WbAddrWidth'(mipsDecodePkg::AddrHold):  rdData = {31'd0, clkEnReg};
            WbAddrWidth'(mipsDecodePkg::AddrCtrl):  rdData = ctrlWord;
            WbAddrWidth'(mipsDecodePkg::AddrImm):   rdData = immWord;
            WbAddrWidth'(mipsDecodePkg::AddrIdx):   rdData = idxWord;
            default:                                rdData = 32'd0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state    <= mipsDecodePkg::wbsIdle;
            wbAck    <= 1'b0;
            instrReg <= 32'd0;
            clkEnReg <= 1'b0;
        end
        else
        begin
            wbAck <= accept;
            if (accept)
            begin
                state <= mipsDecodePkg::wbsAck;
            end
            // Stay busy until the strobe has been seen low
            else if (!(wbCyc && wbStb))
            begin
                state <= mipsDecodePkg::wbsIdle;
            end
            if (accept && wbWe && wbAdr == WbAddrWidth'(mipsDecodePkg::AddrInstr))
            begin
                instrReg <= wbDatI;
            end
            if (accept && wbWe && wbAdr == WbAddrWidth'(mipsDecodePkg::AddrHold))
            begin
                clkEnReg <= wbDatI[0];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept && !wbWe)
        begin
            wbDatO <= rdData;
        end
    end

    ackNeedsCycStb: assert property (@(posedge clk) disable iff (!rstN)
        wbAck |-> (wbCyc && wbStb));

endmodule

`default_nettype wire

// ==== verilog/decodeIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decodeIf (
    input logic clk,
    input logic rstN
);
    // Stored instruction and hold-phase flag
    logic [31:0] instr;
    logic        clkEn;

    // Main decoder results
    logic                        jr;
    logic                        jump;
    logic [1:0]                  regWrite;
    logic                        memRead;
    logic                        memWrite;
    mipsDecodePkg::regDstE       regDst;
    mipsDecodePkg::memToRegE     memToReg;
    logic [1:0]                  hiWrite;
    logic [1:0]                  loWrite;
    logic                        delayEarly;
    mipsDecodePkg::storeTypeE    storeType;

    // Operand decoder results
    logic [4:0]                  rsIdx;
    logic [4:0]                  rtIdx;
    logic [4:0]                  rdIdx;
    logic [4:0]                  shamt;
    mipsDecodePkg::branchCondE   branchCond;
    logic [31:0]                 immExt;

    modport src (output instr, clkEn);

    modport ctrl (
        input  clk, rstN, instr, clkEn,
        output jr, jump, regWrite, memRead, memWrite, regDst, memToReg,
        output hiWrite, loWrite, delayEarly, storeType
    );

    modport opnd (input instr, output rsIdx, rtIdx, rdIdx, shamt, branchCond, immExt);

    modport sink (
        input jr, jump, regWrite, memRead, memWrite, regDst, memToReg,
        input hiWrite, loWrite, delayEarly, storeType,
        input rsIdx, rtIdx, rdIdx, shamt, branchCond, immExt
    );

endinterface

`default_nettype wire

// ==== verilog/mipsDecodePkg.sv ====
`default_nettype none

package mipsDecodePkg;

    // Primary opcodes handled by the decoder
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opRegimm  = 6'h01,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opBlez    = 6'h06,
        opBgtz    = 6'h07,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opXori    = 6'h0e,
        opLui     = 6'h0f,
        opLb      = 6'h20,
        opLh      = 6'h21,
        opLwl     = 6'h22,
        opLw      = 6'h23,
        opLbu     = 6'h24,
        opLhu     = 6'h25,
        opLwr     = 6'h26,
        opSb      = 6'h28,
        opSh      = 6'h29,
        opSw      = 6'h2b
    } opcodeE;

    // SPECIAL funct codes with their own decode
    typedef enum logic [5:0] {
        fnJr    = 6'h08,
        fnJalr  = 6'h09,
        fnMfhi  = 6'h10,
        fnMthi  = 6'h11,
        fnMflo  = 6'h12,
        fnMtlo  = 6'h13,
        fnMult  = 6'h18,
        fnMultu = 6'h19,
        fnDiv   = 6'h1a,
        fnDivu  = 6'h1b
    } functE;

    typedef enum logic [1:0] {selRt = 2'd0, selRd = 2'd1, selRa = 2'd2} regDstE;

    typedef enum logic [2:0] {
        selAlu  = 3'd0,
        selMem  = 3'd1,
        selPc4  = 3'd2,
        selHi   = 3'd3,
        selLo   = 3'd4,
        selLink = 3'd5
    } memToRegE;

    typedef enum logic [1:0] {stWord = 2'd0, stHalf = 2'd1, stByte = 2'd2} storeTypeE;

    typedef enum logic [2:0] {bcNone, bcEq, bcNe, bcLez, bcGtz, bcRegimm} branchCondE;

    typedef enum logic {wbsIdle, wbsAck} wbStateE;

    // Control word layout
    localparam int unsigned CtrlJrPos         = 0;
    localparam int unsigned CtrlJumpPos       = 1;
    localparam int unsigned CtrlRegWriteLo    = 2;
    localparam int unsigned CtrlMemReadPos    = 4;
    localparam int unsigned CtrlMemWritePos   = 5;
    localparam int unsigned CtrlRegDstLo      = 6;
    localparam int unsigned CtrlMemToRegLo    = 8;
    localparam int unsigned CtrlHiWriteLo     = 11;
    localparam int unsigned CtrlLoWriteLo     = 13;
    localparam int unsigned CtrlDelayEarlyPos = 15;
    localparam int unsigned CtrlStoreTypeLo   = 16;

    // Index word layout
    localparam int unsigned IdxRsLo     = 0;
    localparam int unsigned IdxRtLo     = 5;
    localparam int unsigned IdxDestLo   = 10;
    localparam int unsigned IdxShamtLo  = 15;
    localparam int unsigned IdxBranchLo = 20;

    // Register map
    localparam int unsigned AddrInstr = 0;
    localparam int unsigned AddrHold  = 1;
    localparam int unsigned AddrCtrl  = 2;
    localparam int unsigned AddrImm   = 3;
    localparam int unsigned AddrIdx   = 4;

endpackage

`default_nettype wire
